//--- source/sys_ctrl_defs.svh
// System control widths, register offsets, field positions and reset values
`ifndef SYS_CTRL_DEFS_SVH
`define SYS_CTRL_DEFS_SVH

// ========================================
// Bus widths
// ========================================
`define SYS_CTRL_ADDR_W 12  // Offset within the 4 KB window
`define SYS_CTRL_DATA_W 32

// ========================================
// Register offsets
// ========================================
`define OFFS_E_CORE_CLK_RST      12'h000
`define OFFS_P_CORE_CLK_RST      12'h004
`define OFFS_CORE_LINK_CLK_RST   12'h008
`define OFFS_SYS_LINK_CLK_RST    12'h00C
`define OFFS_PERIPH_LINK_CLK_RST 12'h010
`define OFFS_BOOT_ADDR_E         12'h014
`define OFFS_BOOT_ADDR_P         12'h018
`define OFFS_BOOT_HARTID_E       12'h01C
`define OFFS_BOOT_HARTID_P       12'h020
`define OFFS_PLL_E_CORE          12'h024
`define OFFS_PLL_P_CORE          12'h028
`define OFFS_PLL_SYS_LINK        12'h02C

// Field positions and widths
`define CLK_EN_BIT    0
`define RST_N_BIT     1
`define CLK_SRC_BIT   2   // Core link only, read-only
`define PLL_REF_DIV_W 4   // Bits 3:0
`define PLL_FB_DIV_W  12  // Bits 15:4
`define PLL_LOCK_BIT  16  // Read-only

// Register counts
`define NUM_DOMAINS   5
`define NUM_BOOT_REGS 4
`define NUM_PLLS      3
`define NUM_REGS      (`NUM_DOMAINS + `NUM_BOOT_REGS + `NUM_PLLS)

// Reset values
`define RST_DOM_CTRL 5'b11100  // Links running, cores held off
`define RST_HARTID_P 1

`endif

//--- source/sys_ctrl_pkg.sv
// System control types: data word, bus response, write select, readback buses
`include "sys_ctrl_defs.svh"

package sys_ctrl_pkg;

  // Data word on both strobes
  typedef logic [`SYS_CTRL_DATA_W-1:0] word_t;

  // Response codes, same encoding as AXI
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // One-hot write select, bit order follows the offset order
  typedef logic [`NUM_REGS-1:0] reg_sel_t;

  // ========================================
  // Readback buses, one word per register
  // ========================================
  typedef word_t [`NUM_DOMAINS-1:0]   dom_words_t;   // 160 bits
  typedef word_t [`NUM_BOOT_REGS-1:0] boot_words_t;  // 128 bits
  typedef word_t [`NUM_PLLS-1:0]      pll_words_t;   // 96 bits

endpackage

//--- source/sys_ctrl_regmap.sv
// Register map: offset decode, write select, OKAY/SLVERR responses and the
// read data multiplexer over all readback words
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module sys_ctrl_regmap (
  input  logic                        we_i,          // Write strobe
  input  logic [`SYS_CTRL_ADDR_W-1:0] waddr_i,
  input  logic                        re_i,          // Read strobe
  input  logic [`SYS_CTRL_ADDR_W-1:0] raddr_i,
  input  sys_ctrl_pkg::dom_words_t    dom_rdata_i,   // From clock/reset group
  input  sys_ctrl_pkg::boot_words_t   boot_rdata_i,  // From boot group
  input  sys_ctrl_pkg::pll_words_t    pll_rdata_i,   // From PLL group
  output sys_ctrl_pkg::reg_sel_t      wsel_o,
  output sys_ctrl_pkg::resp_e         wresp_o,
  output sys_ctrl_pkg::resp_e         rresp_o,
  output sys_ctrl_pkg::word_t         rdata_o
);
  import sys_ctrl_pkg::*;

  localparam int IDX_W = $clog2(`NUM_REGS);

  typedef logic [IDX_W-1:0] idx_t;

  localparam idx_t IDX_NONE = '1;  // Beyond the last register

  idx_t                  widx;
  idx_t                  ridx;
  word_t [`NUM_REGS-1:0] all_words;  // Index 0 is E core clk/rst

  // Exact match only, unaligned offsets fall to the default
  function automatic idx_t offs_to_idx(input logic [`SYS_CTRL_ADDR_W-1:0] offs);
    case (offs)
      `OFFS_E_CORE_CLK_RST:      return idx_t'(0);
      `OFFS_P_CORE_CLK_RST:      return idx_t'(1);
      `OFFS_CORE_LINK_CLK_RST:   return idx_t'(2);
      `OFFS_SYS_LINK_CLK_RST:    return idx_t'(3);
      `OFFS_PERIPH_LINK_CLK_RST: return idx_t'(4);
      `OFFS_BOOT_ADDR_E:         return idx_t'(5);
      `OFFS_BOOT_ADDR_P:         return idx_t'(6);
      `OFFS_BOOT_HARTID_E:       return idx_t'(7);
      `OFFS_BOOT_HARTID_P:       return idx_t'(8);
      `OFFS_PLL_E_CORE:          return idx_t'(9);
      `OFFS_PLL_P_CORE:          return idx_t'(10);
      `OFFS_PLL_SYS_LINK:        return idx_t'(11);
      default:                   return IDX_NONE;  // Unmapped
    endcase
  endfunction

  assign widx      = offs_to_idx(waddr_i);
  assign ridx      = offs_to_idx(raddr_i);
  assign all_words = {pll_rdata_i, boot_rdata_i, dom_rdata_i};

  // ========================================
  // Write select and response
  // ========================================
  always_comb begin
    wsel_o  = '0;
    wresp_o = RESP_SLVERR;  // Also while idle
    if (we_i && (widx != IDX_NONE)) begin
      wsel_o[widx] = 1'b1;
      wresp_o      = RESP_OKAY;
    end
  end

  // ========================================
  // Read mux and response
  // ========================================
  always_comb begin
    rresp_o = RESP_SLVERR;
    rdata_o = '0;  // Zero data on error or idle
    if (re_i && (ridx != IDX_NONE)) begin
      rresp_o = RESP_OKAY;
      rdata_o = all_words[ridx];
    end
  end

  // A write lands only on the one word that its offset addresses
  always_comb begin
    a_wsel_word : assert (wsel_o == '0 ||
                          wsel_o == (reg_sel_t'(1) << waddr_i[`SYS_CTRL_ADDR_W-1:2]))
      else $error("wsel_o %b does not match offset %h", wsel_o, waddr_i);
  end

endmodule

//--- source/clk_rst_ctrl.sv
// Clock-enable and reset control bits for the five domains, with readback
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module clk_rst_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_ni,
  input  logic [`NUM_DOMAINS-1:0]  wsel_i,               // One bit per domain
  input  sys_ctrl_pkg::word_t      wdata_i,
  input  logic                     core_link_clk_src_i,  // Shown at bit 2
  output logic                     e_core_clk_en_o,
  output logic                     e_core_rst_no,
  output logic                     p_core_clk_en_o,
  output logic                     p_core_rst_no,
  output logic                     core_link_clk_en_o,
  output logic                     core_link_rst_no,
  output logic                     sys_link_clk_en_o,
  output logic                     sys_link_rst_no,
  output logic                     periph_link_clk_en_o,
  output logic                     periph_link_rst_no,
  output sys_ctrl_pkg::dom_words_t rdata_o
);

  // Domain slots, offset order
  localparam int D_E_CORE      = 0;
  localparam int D_P_CORE      = 1;
  localparam int D_CORE_LINK   = 2;
  localparam int D_SYS_LINK    = 3;
  localparam int D_PERIPH_LINK = 4;

  logic [`NUM_DOMAINS-1:0] clk_en_q;
  logic [`NUM_DOMAINS-1:0] rst_n_q;  // Active low per domain

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      clk_en_q <= `RST_DOM_CTRL;
      rst_n_q  <= `RST_DOM_CTRL;
    end else begin
      for (int d = 0; d < `NUM_DOMAINS; d++) begin
        if (wsel_i[d]) begin
          clk_en_q[d] <= wdata_i[`CLK_EN_BIT];
          rst_n_q[d]  <= wdata_i[`RST_N_BIT];
        end
      end
    end
  end

  assign e_core_clk_en_o      = clk_en_q[D_E_CORE];
  assign e_core_rst_no        = rst_n_q[D_E_CORE];
  assign p_core_clk_en_o      = clk_en_q[D_P_CORE];
  assign p_core_rst_no        = rst_n_q[D_P_CORE];
  assign core_link_clk_en_o   = clk_en_q[D_CORE_LINK];
  assign core_link_rst_no     = rst_n_q[D_CORE_LINK];
  assign sys_link_clk_en_o    = clk_en_q[D_SYS_LINK];
  assign sys_link_rst_no      = rst_n_q[D_SYS_LINK];
  assign periph_link_clk_en_o = clk_en_q[D_PERIPH_LINK];
  assign periph_link_rst_no   = rst_n_q[D_PERIPH_LINK];

  // Readback, upper bits zero
  always_comb begin
    for (int d = 0; d < `NUM_DOMAINS; d++) begin
      rdata_o[d]              = '0;
      rdata_o[d][`CLK_EN_BIT] = clk_en_q[d];
      rdata_o[d][`RST_N_BIT]  = rst_n_q[d];
    end
    rdata_o[D_CORE_LINK][`CLK_SRC_BIT] = core_link_clk_src_i;  // Live input
  end

  // Decode upstream must never hit two domains at once
  a_wsel_onehot0 : assert property (@(posedge clk_i) disable iff (!arst_ni)
    $onehot0(wsel_i))
    else $error("clk_rst_ctrl: multiple domain selects %b", wsel_i);

endmodule

//--- source/boot_cfg.sv
// Boot address and boot hart ID registers for the E and P cores
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module boot_cfg (
  input  logic                       clk_i,
  input  logic                       arst_ni,
  input  logic [`NUM_BOOT_REGS-1:0]  wsel_i,
  input  sys_ctrl_pkg::word_t        wdata_i,
  output sys_ctrl_pkg::word_t        boot_addr_e_core_o,
  output sys_ctrl_pkg::word_t        boot_addr_p_core_o,
  output sys_ctrl_pkg::word_t        boot_hartid_e_core_o,
  output sys_ctrl_pkg::word_t        boot_hartid_p_core_o,
  output sys_ctrl_pkg::boot_words_t  rdata_o
);
  import sys_ctrl_pkg::*;

  // Only the P core hart ID is nonzero after reset
  localparam boot_words_t BOOT_RST = {word_t'(`RST_HARTID_P), word_t'(0), word_t'(0),
                                      word_t'(0)};

  boot_words_t boot_q;  // Addr E, addr P, hart E, hart P

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      boot_q <= BOOT_RST;
    end else begin
      for (int i = 0; i < `NUM_BOOT_REGS; i++) begin
        if (wsel_i[i]) boot_q[i] <= wdata_i;  // Full word
      end
    end
  end

  assign boot_addr_e_core_o   = boot_q[0];
  assign boot_addr_p_core_o   = boot_q[1];
  assign boot_hartid_e_core_o = boot_q[2];
  assign boot_hartid_p_core_o = boot_q[3];

  assign rdata_o = boot_q;  // All fields read back as stored

endmodule

//--- source/pll_cfg.sv
// Reference and feedback divider registers for three PLLs,
// readback with live lock status
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module pll_cfg (
  input  logic                       clk_i,
  input  logic                       arst_ni,
  input  logic [`NUM_PLLS-1:0]       wsel_i,
  input  sys_ctrl_pkg::word_t        wdata_i,
  input  logic                       pll_locked_e_core_i,
  input  logic                       pll_locked_p_core_i,
  input  logic                       pll_locked_sys_link_i,
  output logic [`PLL_REF_DIV_W-1:0]  pll_ref_div_e_core_o,
  output logic [`PLL_FB_DIV_W-1:0]   pll_fb_div_e_core_o,
  output logic [`PLL_REF_DIV_W-1:0]  pll_ref_div_p_core_o,
  output logic [`PLL_FB_DIV_W-1:0]   pll_fb_div_p_core_o,
  output logic [`PLL_REF_DIV_W-1:0]  pll_ref_div_sys_link_o,
  output logic [`PLL_FB_DIV_W-1:0]   pll_fb_div_sys_link_o,
  output sys_ctrl_pkg::pll_words_t   rdata_o
);

  localparam int FB_LSB = `PLL_REF_DIV_W;  // Feedback field sits above ref

  logic [`NUM_PLLS-1:0][`PLL_REF_DIV_W-1:0] ref_div_q;
  logic [`NUM_PLLS-1:0][`PLL_FB_DIV_W-1:0]  fb_div_q;
  logic [`NUM_PLLS-1:0]                     locked;

  assign locked = {pll_locked_sys_link_i, pll_locked_p_core_i, pll_locked_e_core_i};

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      ref_div_q <= '0;
      fb_div_q  <= '0;
    end else begin
      for (int i = 0; i < `NUM_PLLS; i++) begin
        if (wsel_i[i]) begin
          ref_div_q[i] <= wdata_i[`PLL_REF_DIV_W-1:0];
          fb_div_q[i]  <= wdata_i[FB_LSB +: `PLL_FB_DIV_W];
        end
      end
    end
  end

  // E core, P core, system link
  assign pll_ref_div_e_core_o   = ref_div_q[0];
  assign pll_fb_div_e_core_o    = fb_div_q[0];
  assign pll_ref_div_p_core_o   = ref_div_q[1];
  assign pll_fb_div_p_core_o    = fb_div_q[1];
  assign pll_ref_div_sys_link_o = ref_div_q[2];
  assign pll_fb_div_sys_link_o  = fb_div_q[2];

  always_comb begin
    for (int i = 0; i < `NUM_PLLS; i++) begin
      rdata_o[i]                                = '0;
      rdata_o[i][`PLL_REF_DIV_W-1:0]            = ref_div_q[i];
      rdata_o[i][FB_LSB +: `PLL_FB_DIV_W]       = fb_div_q[i];
      rdata_o[i][`PLL_LOCK_BIT]                 = locked[i];  // Read-only
    end
  end

  // Active reference divider needs a feedback divider
  a_div_pair : assert property (@(posedge clk_i) disable iff (!arst_ni)
    (|wsel_i) |-> ((wdata_i[`PLL_REF_DIV_W-1:0] == '0) ||
                   (wdata_i[FB_LSB +: `PLL_FB_DIV_W] != '0)))
    else $error("pll_cfg: ref divider written without feedback divider");

endmodule

//--- source/sys_ctrl.sv
// System control top: register map plus clock/reset, boot and PLL groups
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module sys_ctrl (
  input  logic                        clk_i,
  input  logic                        arst_ni,
  // ========================================
  // Memory strobes
  // ========================================
  input  logic                        we_i,
  input  logic [`SYS_CTRL_ADDR_W-1:0] waddr_i,
  input  sys_ctrl_pkg::word_t         wdata_i,
  output sys_ctrl_pkg::resp_e         wresp_o,   // Same cycle as we_i
  input  logic                        re_i,
  input  logic [`SYS_CTRL_ADDR_W-1:0] raddr_i,
  output sys_ctrl_pkg::word_t         rdata_o,   // Same cycle as re_i
  output sys_ctrl_pkg::resp_e         rresp_o,
  // ========================================
  // Domain control
  // ========================================
  output logic                        e_core_clk_en_o,
  output logic                        e_core_rst_no,
  output logic                        p_core_clk_en_o,
  output logic                        p_core_rst_no,
  output logic                        core_link_clk_en_o,
  output logic                        core_link_rst_no,
  input  logic                        core_link_clk_src_i,
  output logic                        sys_link_clk_en_o,
  output logic                        sys_link_rst_no,
  output logic                        periph_link_clk_en_o,
  output logic                        periph_link_rst_no,
  // Boot configuration
  output sys_ctrl_pkg::word_t         boot_addr_e_core_o,
  output sys_ctrl_pkg::word_t         boot_addr_p_core_o,
  output sys_ctrl_pkg::word_t         boot_hartid_e_core_o,
  output sys_ctrl_pkg::word_t         boot_hartid_p_core_o,
  // PLL configuration
  output logic [`PLL_REF_DIV_W-1:0]   pll_ref_div_e_core_o,
  output logic [`PLL_FB_DIV_W-1:0]    pll_fb_div_e_core_o,
  input  logic                        pll_locked_e_core_i,
  output logic [`PLL_REF_DIV_W-1:0]   pll_ref_div_p_core_o,
  output logic [`PLL_FB_DIV_W-1:0]    pll_fb_div_p_core_o,
  input  logic                        pll_locked_p_core_i,
  output logic [`PLL_REF_DIV_W-1:0]   pll_ref_div_sys_link_o,
  output logic [`PLL_FB_DIV_W-1:0]    pll_fb_div_sys_link_o,
  input  logic                        pll_locked_sys_link_i
);
  import sys_ctrl_pkg::*;

  // Select slices, offset order
  localparam int BOOT_LSB = `NUM_DOMAINS;
  localparam int PLL_LSB  = BOOT_LSB + `NUM_BOOT_REGS;

  reg_sel_t    wsel;
  dom_words_t  dom_rdata;
  boot_words_t boot_rdata;
  pll_words_t  pll_rdata;

  sys_ctrl_regmap u_regmap (
    .we_i         (we_i),
    .waddr_i      (waddr_i),
    .re_i         (re_i),
    .raddr_i      (raddr_i),
    .dom_rdata_i  (dom_rdata),
    .boot_rdata_i (boot_rdata),
    .pll_rdata_i  (pll_rdata),
    .wsel_o       (wsel),
    .wresp_o      (wresp_o),
    .rresp_o      (rresp_o),
    .rdata_o      (rdata_o)
  );

  clk_rst_ctrl u_clk_rst (
    .clk_i                (clk_i),
    .arst_ni              (arst_ni),
    .wsel_i               (wsel[`NUM_DOMAINS-1:0]),
    .wdata_i              (wdata_i),
    .core_link_clk_src_i  (core_link_clk_src_i),
    .e_core_clk_en_o      (e_core_clk_en_o),
    .e_core_rst_no        (e_core_rst_no),
    .p_core_clk_en_o      (p_core_clk_en_o),
    .p_core_rst_no        (p_core_rst_no),
    .core_link_clk_en_o   (core_link_clk_en_o),
    .core_link_rst_no     (core_link_rst_no),
    .sys_link_clk_en_o    (sys_link_clk_en_o),
    .sys_link_rst_no      (sys_link_rst_no),
    .periph_link_clk_en_o (periph_link_clk_en_o),
    .periph_link_rst_no   (periph_link_rst_no),
    .rdata_o              (dom_rdata)
  );

  boot_cfg u_boot (
    .clk_i                (clk_i),
    .arst_ni              (arst_ni),
    .wsel_i               (wsel[BOOT_LSB +: `NUM_BOOT_REGS]),
    .wdata_i              (wdata_i),
    .boot_addr_e_core_o   (boot_addr_e_core_o),
    .boot_addr_p_core_o   (boot_addr_p_core_o),
    .boot_hartid_e_core_o (boot_hartid_e_core_o),
    .boot_hartid_p_core_o (boot_hartid_p_core_o),
    .rdata_o              (boot_rdata)
  );

  pll_cfg u_pll (
    .clk_i                  (clk_i),
    .arst_ni                (arst_ni),
    .wsel_i                 (wsel[PLL_LSB +: `NUM_PLLS]),
    .wdata_i                (wdata_i),
    .pll_locked_e_core_i    (pll_locked_e_core_i),
    .pll_locked_p_core_i    (pll_locked_p_core_i),
    .pll_locked_sys_link_i  (pll_locked_sys_link_i),
    .pll_ref_div_e_core_o   (pll_ref_div_e_core_o),
    .pll_fb_div_e_core_o    (pll_fb_div_e_core_o),
    .pll_ref_div_p_core_o   (pll_ref_div_p_core_o),
    .pll_fb_div_p_core_o    (pll_fb_div_p_core_o),
    .pll_ref_div_sys_link_o (pll_ref_div_sys_link_o),
    .pll_fb_div_sys_link_o  (pll_fb_div_sys_link_o),
    .rdata_o                (pll_rdata)
  );

endmodule

//--- bench/sys_ctrl_tb.sv
// Testbench for the system control block: clock, reset, stimulus table
// with expected values, port and response checks, closing report
`timescale 1ns/1ps
`include "sys_ctrl_defs.svh"

module sys_ctrl_tb;
  import sys_ctrl_pkg::*;

  localparam int         RST_CYCLES  = 16;
  localparam int         RST_TIMEOUT = 64;   // Cycles allowed for reset release
  localparam logic [1:0] OP_WR       = 2'b01;  // Bit 0 is we_i, bit 1 is re_i
  localparam logic [1:0] OP_RD       = 2'b10;
  localparam logic [1:0] OP_BOTH     = 2'b11;
  localparam int         PLL_SLOT    = `NUM_DOMAINS + `NUM_BOOT_REGS;

  typedef struct {
    string                       name;
    logic [1:0]                  op;
    logic [`SYS_CTRL_ADDR_W-1:0] addr;
    word_t                       wdata;
    logic [2:0]                  lock;     // Sys link, P core, E core
    logic                        clk_src;
    resp_e                       exp_resp;
    word_t                       exp_rdata;
  } entry_t;

  entry_t tbl[$];
  word_t  shadow [`NUM_REGS];  // Fields each register holds
  word_t  lcg_state;
  int     checks;
  int     errors;
  int     wait_cnt;

  // DUT ports
  logic  clk_i, arst_ni, we_i, re_i;
  logic  [`SYS_CTRL_ADDR_W-1:0] waddr_i, raddr_i;
  word_t wdata_i, rdata_o;
  resp_e wresp_o, rresp_o;
  logic  core_link_clk_src_i;
  logic  pll_locked_e_core_i, pll_locked_p_core_i, pll_locked_sys_link_i;
  logic  e_core_clk_en_o, p_core_clk_en_o, core_link_clk_en_o;
  logic  sys_link_clk_en_o, periph_link_clk_en_o;
  logic  e_core_rst_no, p_core_rst_no, core_link_rst_no, sys_link_rst_no, periph_link_rst_no;
  word_t boot_addr_e_core_o, boot_addr_p_core_o, boot_hartid_e_core_o, boot_hartid_p_core_o;
  logic  [`PLL_REF_DIV_W-1:0] pll_ref_div_e_core_o, pll_ref_div_p_core_o, pll_ref_div_sys_link_o;
  logic  [`PLL_FB_DIV_W-1:0]  pll_fb_div_e_core_o, pll_fb_div_p_core_o, pll_fb_div_sys_link_o;

  sys_ctrl UUT (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;  // 4 ns period

  initial begin
    arst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    arst_ni <= 1'b1;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic word_t lcg_next(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word slot of an offset, -1 when unmapped
  function automatic int reg_index(input logic [`SYS_CTRL_ADDR_W-1:0] offs);
    if (offs[1:0] != 2'b00 || offs >= 12'h030) return -1;  // Unaligned or past the map
    return int'(offs >> 2);
  endfunction

  function automatic word_t keep_mask(input int idx);
    if (idx < `NUM_DOMAINS) return 32'h0000_0003;  // Clock enable and reset
    if (idx < PLL_SLOT) return 32'hFFFF_FFFF;
    return 32'h0000_FFFF;  // Both dividers
  endfunction

  function automatic word_t readback(input int idx, input logic [2:0] lock, input logic src);
    word_t w;
    w = shadow[idx];
    if (idx == 2) w[`CLK_SRC_BIT] = src;  // Core link clock source, live
    if (idx >= PLL_SLOT) w[`PLL_LOCK_BIT] = lock[idx - PLL_SLOT];
    return w;
  endfunction

  task automatic reset_shadow();
    for (int i = 0; i < `NUM_REGS; i++) begin
      shadow[i] = (i >= 2 && i < `NUM_DOMAINS) ? 32'h3 : 32'h0;  // Links run, cores off
    end
    shadow[`NUM_DOMAINS + 3] = `RST_HARTID_P;  // P core hart ID
  endtask

  task automatic store_write(input logic [1:0] op, input logic [11:0] addr, input word_t data);
    int idx;
    idx = reg_index(addr);
    if (op[0] && idx >= 0) shadow[idx] = data & keep_mask(idx);
  endtask

  task automatic add_entry(input string name, input logic [1:0] op, input logic [11:0] addr,
                           input word_t wdata, input logic [2:0] lock, input logic src);
    entry_t e;
    int     idx;
    idx         = reg_index(addr);
    e.name      = name;
    e.op        = op;
    e.addr      = addr;
    e.wdata     = wdata;
    e.lock      = lock;
    e.clk_src   = src;
    e.exp_resp  = (idx < 0) ? RESP_SLVERR : RESP_OKAY;
    e.exp_rdata = (idx < 0 || !op[1]) ? '0 : readback(idx, lock, src);  // Old value
    store_write(op, addr, wdata);
    tbl.push_back(e);
  endtask

  // ========================================
  // Stimulus table
  // ========================================
  task automatic fill_table();
    word_t w;
    reset_shadow();
    lcg_state = 32'hf8b9;
    for (int i = 0; i < `NUM_REGS; i++)
      add_entry($sformatf("rst_rd_%0d", i), OP_RD, 12'(i * 4), '0, 3'b000, 1'b0);
    for (int d = 0; d < `NUM_DOMAINS; d++)  // Patterns 01 10 11 00 01, junk above
      add_entry($sformatf("dom_wr_%0d", d), OP_WR, 12'(d * 4),
                32'hA5A5_A5A4 | word_t'((d + 1) % 4), 3'b000, 1'b1);
    for (int d = 0; d < `NUM_DOMAINS; d++)
      add_entry($sformatf("dom_rd_%0d", d), OP_RD, 12'(d * 4), '0, 3'b000, 1'(d % 2));
    add_entry("dom_rd_src", OP_RD, `OFFS_CORE_LINK_CLK_RST, '0, 3'b000, 1'b1);
    for (int i = 0; i < `NUM_BOOT_REGS; i++) begin
      lcg_state = lcg_next(lcg_state);
      add_entry($sformatf("boot_wr_%0d", i), OP_WR, `OFFS_BOOT_ADDR_E + 12'(i * 4),
                lcg_state, 3'b000, 1'b0);
    end
    for (int i = 0; i < `NUM_BOOT_REGS; i++)
      add_entry($sformatf("boot_rd_%0d", i), OP_RD, `OFFS_BOOT_ADDR_E + 12'(i * 4),
                '0, 3'b000, 1'b0);
    for (int i = 0; i < `NUM_PLLS; i++) begin
      lcg_state = lcg_next(lcg_state);
      w = lcg_state | 32'h8000_0010;  // Upper junk, feedback never zero
      add_entry($sformatf("pll_wr_%0d", i), OP_WR, `OFFS_PLL_E_CORE + 12'(i * 4),
                w, 3'(i), 1'b0);
    end
    // Each PLL read alone locked, then alone unlocked
    for (int i = 0; i < 2 * `NUM_PLLS; i++)
      add_entry($sformatf("pll_rd_%0d", i), OP_RD, `OFFS_PLL_E_CORE + 12'((i % 3) * 4),
                '0, (i < `NUM_PLLS) ? 3'(1 << (i % 3)) : ~3'(1 << (i % 3)), 1'b0);
    add_entry("unmapped_wr", OP_WR, 12'h030, 32'hFFFF_FFFF, 3'b000, 1'b0);
    add_entry("unaligned_wr", OP_WR, 12'h005, 32'hFFFF_FFFF, 3'b000, 1'b0);
    add_entry("unmapped_rd", OP_RD, 12'h030, '0, 3'b000, 1'b0);
    add_entry("unaligned_rd", OP_RD, 12'h005, '0, 3'b000, 1'b0);
    add_entry("top_rd", OP_RD, 12'hFFC, '0, 3'b111, 1'b1);
    lcg_state = lcg_next(lcg_state);
    add_entry("same_cyc_boot", OP_BOTH, `OFFS_BOOT_ADDR_P, lcg_state, 3'b000, 1'b0);
    add_entry("after_boot", OP_RD, `OFFS_BOOT_ADDR_P, '0, 3'b000, 1'b0);
    add_entry("same_cyc_dom", OP_BOTH, `OFFS_E_CORE_CLK_RST, 32'h3, 3'b000, 1'b1);
    add_entry("after_dom", OP_RD, `OFFS_E_CORE_CLK_RST, '0, 3'b000, 1'b1);
  endtask

  // ========================================
  // Checks and table replay
  // ========================================
  task automatic check_val(input string name, input string what, input word_t exp,
                           input word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_ports(input string name);
    logic [4:0] en_exp;
    logic [4:0] rst_exp;
    for (int d = 0; d < `NUM_DOMAINS; d++) begin
      en_exp[d]  = shadow[d][`CLK_EN_BIT];
      rst_exp[d] = shadow[d][`RST_N_BIT];
    end
    check_val(name, "clk_en", word_t'(en_exp), word_t'({periph_link_clk_en_o,
              sys_link_clk_en_o, core_link_clk_en_o, p_core_clk_en_o, e_core_clk_en_o}));
    check_val(name, "rst_n", word_t'(rst_exp), word_t'({periph_link_rst_no,
              sys_link_rst_no, core_link_rst_no, p_core_rst_no, e_core_rst_no}));
    check_val(name, "boot_addr_e", shadow[5], boot_addr_e_core_o);
    check_val(name, "boot_addr_p", shadow[6], boot_addr_p_core_o);
    check_val(name, "hartid_e", shadow[7], boot_hartid_e_core_o);
    check_val(name, "hartid_p", shadow[8], boot_hartid_p_core_o);
    check_val(name, "pll_e", shadow[9], word_t'({pll_fb_div_e_core_o, pll_ref_div_e_core_o}));
    check_val(name, "pll_p", shadow[10], word_t'({pll_fb_div_p_core_o, pll_ref_div_p_core_o}));
    check_val(name, "pll_sys", shadow[11],
              word_t'({pll_fb_div_sys_link_o, pll_ref_div_sys_link_o}));
  endtask

  task automatic apply_table();
    entry_t e;
    reset_shadow();
    foreach (tbl[k]) begin
      e = tbl[k];
      @(posedge clk_i);
      we_i                <= e.op[0];
      re_i                <= e.op[1];
      waddr_i             <= e.addr;
      raddr_i             <= e.addr;
      wdata_i             <= e.wdata;
      core_link_clk_src_i <= e.clk_src;
      {pll_locked_sys_link_i, pll_locked_p_core_i, pll_locked_e_core_i} <= e.lock;
      @(negedge clk_i);  // Mid-cycle, responses settled
      check_ports(e.name);  // Writes up to the previous entry
      if (e.op[0]) check_val(e.name, "wresp", word_t'(e.exp_resp), word_t'(wresp_o));
      if (e.op[1]) begin
        check_val(e.name, "rresp", word_t'(e.exp_resp), word_t'(rresp_o));
        check_val(e.name, "rdata", e.exp_rdata, rdata_o);
      end
      store_write(e.op, e.addr, e.wdata);
    end
    @(posedge clk_i);
    we_i <= 1'b0;
    re_i <= 1'b0;
    @(negedge clk_i);
    check_ports("idle");  // Last write landed
    check_val("idle", "wresp", word_t'(RESP_SLVERR), word_t'(wresp_o));
    check_val("idle", "rresp", word_t'(RESP_SLVERR), word_t'(rresp_o));
    check_val("idle", "rdata", '0, rdata_o);
  endtask

  initial begin
    checks                = 0;
    errors                = 0;
    wait_cnt              = 0;
    we_i                  = 1'b0;
    re_i                  = 1'b0;
    waddr_i               = '0;
    raddr_i               = '0;
    wdata_i               = '0;
    core_link_clk_src_i   = 1'b0;
    pll_locked_e_core_i   = 1'b0;
    pll_locked_p_core_i   = 1'b0;
    pll_locked_sys_link_i = 1'b0;
    fill_table();
    while (arst_ni !== 1'b1 && wait_cnt < RST_TIMEOUT) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (arst_ni !== 1'b1) begin
      errors++;
      $display("Reset was still asserted after %0d cycles", RST_TIMEOUT);
    end else begin
      apply_table();
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- project.f
+incdir+source
source/sys_ctrl_pkg.sv
source/sys_ctrl_regmap.sv
source/clk_rst_ctrl.sv
source/boot_cfg.sv
source/pll_cfg.sv
source/sys_ctrl.sv
bench/sys_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the system control testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module sys_ctrl_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vsys_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0
